// File: Bender.yml
package:
  name: can_acf

sources:
  - include_dirs:
      - design
    files:
      - design/can_acf_reg_pkg.sv
      - design/can_frame_pkg.sv
      - design/can_acf_regs.sv
      - design/can_acf_std_match.sv
      - design/can_acf_ext_match.sv
      - design/can_acf_decide.sv
      - design/can_acf.sv
  - target: test
    files:
      - verif/can_acf_asserts.sv
      - verif/can_acf_checker.sv
      - verif/tb_can_acf.sv

// File: can_acf.f
+incdir+design
design/can_acf_reg_pkg.sv
design/can_frame_pkg.sv
design/can_acf_regs.sv
design/can_acf_std_match.sv
design/can_acf_ext_match.sv
design/can_acf_decide.sv
design/can_acf.sv
verif/can_acf_asserts.sv
verif/can_acf_checker.sv
verif/tb_can_acf.sv

// File: design/can_acf.sv
// CAN acceptance filter top level
`timescale 1ns/1ps
`default_nettype none

module can_acf (
  input  logic                       clk,
  input  logic                       rst,
  // Mode bits
  input  logic                       reset_mode,
  input  logic                       extended_mode,
  input  logic                       acceptance_filter_mode,
  // Frame fields, stable while go_rx_crc_lim is high
  input  can_frame_pkg::can_ext_id_t id,
  input  logic                       rtr1,
  input  logic                       rtr2,
  input  logic                       ide,
  input  can_frame_pkg::can_data_t   data0,
  input  can_frame_pkg::can_data_t   data1,
  input  logic                       no_byte0,
  input  logic                       no_byte1,
  // Receive events
  input  logic                       go_rx_crc_lim,
  input  logic                       go_rx_inter,
  input  logic                       go_error_frame,
  // Wishbone classic slave
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  can_acf_reg_pkg::acf_reg_e  wb_adr,
  input  can_acf_reg_pkg::acf_byte_t wb_dat_w,
  output logic                       wb_ack,
  output can_acf_reg_pkg::acf_byte_t wb_dat_r,
  output logic                       id_ok
);

  import can_acf_reg_pkg::*;

  acf_bank_t acf_code;
  acf_bank_t acf_mask;
  logic      match_basic;
  logic      match_sf_std;
  logic      match_df_std;
  logic      match_sf_ext;
  logic      match_df_ext;

  ////////////////////////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////////////////////////

  can_acf_regs regs_i (
    .clk      (clk),
    .rst      (rst),
    .reset_mode (reset_mode),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .acf_code (acf_code),
    .acf_mask (acf_mask)
  );

  ////////////////////////////////////////////////////////////
  // Matchers side by side, decision picks one
  ////////////////////////////////////////////////////////////

  can_acf_std_match std_match_i (
    .id           (id),
    .rtr1         (rtr1),
    .data0        (data0),
    .data1        (data1),
    .no_byte0     (no_byte0),
    .no_byte1     (no_byte1),
    .acf_code     (acf_code),
    .acf_mask     (acf_mask),
    .match_basic  (match_basic),
    .match_sf_std (match_sf_std),
    .match_df_std (match_df_std)
  );

  can_acf_ext_match ext_match_i (
    .id           (id),
    .rtr2         (rtr2),
    .acf_code     (acf_code),
    .acf_mask     (acf_mask),
    .match_sf_ext (match_sf_ext),
    .match_df_ext (match_df_ext)
  );

  can_acf_decide decide_i (
    .clk                    (clk),
    .rst                    (rst),
    .extended_mode          (extended_mode),
    .acceptance_filter_mode (acceptance_filter_mode),
    .ide                    (ide),
    .reset_mode             (reset_mode),
    .go_rx_crc_lim          (go_rx_crc_lim),
    .go_rx_inter            (go_rx_inter),
    .go_error_frame         (go_error_frame),
    .match_basic            (match_basic),
    .match_sf_std           (match_sf_std),
    .match_sf_ext           (match_sf_ext),
    .match_df_std           (match_df_std),
    .match_df_ext           (match_df_ext),
    .id_ok                  (id_ok)
  );

endmodule

`default_nettype wire

// File: design/can_acf_consts.svh
// CAN acceptance filter constants
`ifndef CAN_ACF_CONSTS_SVH
`define CAN_ACF_CONSTS_SVH

// Identifier widths fixed by the CAN standard
// Extended frame, 29-bit identifier
`define ACF_EXT_ID_W 29
// Standard frame, 11-bit identifier
`define ACF_STD_ID_W 11

// Code bytes and mask bytes, four of each
`define ACF_NUM_BYTES 4

// Word address, top bit selects the mask bank
`define ACF_WB_ADR_W 3

`endif

// File: design/can_acf_decide.sv
// Acceptance decision and id_ok register
`timescale 1ns/1ps
`default_nettype none

module can_acf_decide (
  input  logic clk,
  input  logic rst,
  input  logic extended_mode,
  input  logic acceptance_filter_mode,
  input  logic ide,
  input  logic reset_mode,
  input  logic go_rx_crc_lim,
  input  logic go_rx_inter,
  input  logic go_error_frame,
  input  logic match_basic,
  input  logic match_sf_std,
  input  logic match_sf_ext,
  input  logic match_df_std,
  input  logic match_df_ext,
  output logic id_ok
);

  import can_frame_pkg::*;

  acf_mode_e mode;
  logic      sel_match;

  // Filter mode bit high selects the single filter
  assign mode = !extended_mode         ? BASIC  :
                acceptance_filter_mode ? SINGLE : DUAL;

  // Result for the active layout and frame format
  always_comb
  begin
    case (mode)
      SINGLE:  sel_match = ide ? match_sf_ext : match_sf_std;
      DUAL:    sel_match = ide ? match_df_ext : match_df_std;
      default: sel_match = match_basic;
    endcase
  end

  // End of CRC samples the match, clears follow unless it is present
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      id_ok <= 1'b0;
    else if (go_rx_crc_lim)
      id_ok <= sel_match;
    else if (reset_mode | go_rx_inter | go_error_frame)
      id_ok <= 1'b0;
  end

endmodule

`default_nettype wire

// File: design/can_acf_ext_match.sv
// Extended frame identifier matcher
`timescale 1ns/1ps
`default_nettype none

`include "can_acf_consts.svh"

module can_acf_ext_match (
  input  can_frame_pkg::can_ext_id_t  id,
  input  logic                        rtr2,
  input  can_acf_reg_pkg::acf_bank_t  acf_code,
  input  can_acf_reg_pkg::acf_bank_t  acf_mask,
  output logic                        match_sf_ext,
  output logic                        match_df_ext
);

  import can_acf_reg_pkg::*;
  import can_frame_pkg::*;

  logic b0_pass;
  logic b1_pass;
  logic b2_sf_pass;
  logic b3_sf_pass;
  logic b2_df_pass;
  logic b3_df_pass;

  ////////////////////////////////////////////////////////////
  // Single filter, whole identifier plus rtr
  ////////////////////////////////////////////////////////////

  // Top bits against byte 0, shared with dual filter 1
  assign b0_pass    = &(~(id[`ACF_EXT_ID_W-1:21] ^ acf_code[0]) | acf_mask[0]);
  assign b1_pass    = &(~(id[20:13] ^ acf_code[1]) | acf_mask[1]);
  assign b2_sf_pass = &(~(id[12:5] ^ acf_code[2]) | acf_mask[2]);
  // Bits 1..0 of byte 3 are unused
  assign b3_sf_pass = &(~({id[4:0], rtr2} ^ acf_code[3][7:2]) | acf_mask[3][7:2]);

  assign match_sf_ext = b0_pass & b1_pass & b2_sf_pass & b3_sf_pass;

  ////////////////////////////////////////////////////////////
  // Dual filter, id bits 28..13 twice
  ////////////////////////////////////////////////////////////

  // Filter 2 repeats the layout on bytes 2 and 3
  assign b2_df_pass = &(~(id[`ACF_EXT_ID_W-1:21] ^ acf_code[2]) | acf_mask[2]);
  assign b3_df_pass = &(~(id[20:13] ^ acf_code[3]) | acf_mask[3]);

  assign match_df_ext = (b0_pass & b1_pass) | (b2_df_pass & b3_df_pass);

endmodule

`default_nettype wire

// File: design/can_acf_reg_pkg.sv
// Acceptance filter register types
`default_nettype none

`include "can_acf_consts.svh"

package can_acf_reg_pkg;

  // One code or mask byte
  typedef logic [7:0] acf_byte_t;

  // Four filter bytes, byte 0 in the low lane
  typedef acf_byte_t [`ACF_NUM_BYTES-1:0] acf_bank_t;

  // Register map, codes at 0..3 and masks at 4..7
  typedef enum logic [`ACF_WB_ADR_W-1:0] {
    CODE0, CODE1, CODE2, CODE3,
    MASK0, MASK1, MASK2, MASK3
  } acf_reg_e;

endpackage

`default_nettype wire

// File: design/can_acf_regs.sv
// Acceptance code and mask registers
`timescale 1ns/1ps
`default_nettype none

`include "can_acf_consts.svh"

module can_acf_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       reset_mode,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  can_acf_reg_pkg::acf_reg_e  wb_adr,
  input  can_acf_reg_pkg::acf_byte_t wb_dat_w,
  output logic                       wb_ack,
  output can_acf_reg_pkg::acf_byte_t wb_dat_r,
  output can_acf_reg_pkg::acf_bank_t acf_code,
  output can_acf_reg_pkg::acf_bank_t acf_mask
);

  import can_acf_reg_pkg::*;

  ////////////////////////////////////////////////////////////
  // Address decode and handshake
  ////////////////////////////////////////////////////////////

  logic                              req;
  logic                              wr_en;
  logic                              sel_mask;
  logic [$clog2(`ACF_NUM_BYTES)-1:0] byte_idx;

  // New request only while no ack is pending
  assign req      = wb_cyc & wb_stb & ~wb_ack;
  // Filter bytes are writable in reset mode only
  assign wr_en    = req & wb_we & reset_mode;
  // Top address bit picks the mask bank
  assign sel_mask = wb_adr[`ACF_WB_ADR_W-1];
  assign byte_idx = wb_adr[$clog2(`ACF_NUM_BYTES)-1:0];

  // Single-cycle classic ack, one edge after the request
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      wb_ack <= 1'b0;
    else
      wb_ack <= req;
  end

  ////////////////////////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////////////////////////

  // Byte is stored on the edge that raises ack
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      acf_code <= '0;
      acf_mask <= '0;
    end
    else if (wr_en)
    begin
      if (sel_mask)
        acf_mask[byte_idx] <= wb_dat_w;
      else
        acf_code[byte_idx] <= wb_dat_w;
    end
  end

  // Readback of the addressed byte, held stable by the master during ack
  assign wb_dat_r = sel_mask ? acf_mask[byte_idx] : acf_code[byte_idx];

endmodule

`default_nettype wire

// File: design/can_acf_std_match.sv
// Standard frame identifier matcher
`timescale 1ns/1ps
`default_nettype none

`include "can_acf_consts.svh"

module can_acf_std_match (
  input  can_frame_pkg::can_ext_id_t  id,
  input  logic                        rtr1,
  input  can_frame_pkg::can_data_t    data0,
  input  can_frame_pkg::can_data_t    data1,
  input  logic                        no_byte0,
  input  logic                        no_byte1,
  input  can_acf_reg_pkg::acf_bank_t  acf_code,
  input  can_acf_reg_pkg::acf_bank_t  acf_mask,
  output logic                        match_basic,
  output logic                        match_sf_std,
  output logic                        match_df_std
);

  import can_acf_reg_pkg::*;
  import can_frame_pkg::*;

  can_std_id_t std_id;
  logic [3:0]  id_lo;
  logic        hi0_pass;
  logic        lo1_pass;
  logic        d0_sf_pass;
  logic        d1_sf_pass;
  logic        d0_df_pass;
  logic        hi2_pass;
  logic        lo3_pass;

  // Standard identifier sits in the low bits
  assign std_id = id[`ACF_STD_ID_W-1:0];
  // Low id bits followed by rtr, matches bits 7..4 of a filter byte
  assign id_lo  = {std_id[2:0], rtr1};

  ////////////////////////////////////////////////////////////
  // Per-field compares, a bit passes on equal code or set mask
  ////////////////////////////////////////////////////////////

  assign hi0_pass   = &(~(std_id[10:3] ^ acf_code[0]) | acf_mask[0]);
  assign lo1_pass   = &(~(id_lo ^ acf_code[1][7:4]) | acf_mask[1][7:4]);

  // Absent data byte always passes
  assign d0_sf_pass = &(~(data0 ^ acf_code[2]) | acf_mask[2]) | no_byte0;
  assign d1_sf_pass = &(~(data1 ^ acf_code[3]) | acf_mask[3]) | no_byte1;

  // Dual filter 1 spreads data0 over low nibbles of bytes 1 and 3
  assign d0_df_pass = &(~(data0 ^ {acf_code[1][3:0], acf_code[3][3:0]})
                        | {acf_mask[1][3:0], acf_mask[3][3:0]}) | no_byte0;

  // Dual filter 2 uses bytes 2 and 3
  assign hi2_pass   = &(~(std_id[10:3] ^ acf_code[2]) | acf_mask[2]);
  assign lo3_pass   = &(~(id_lo ^ acf_code[3][7:4]) | acf_mask[3][7:4]);

  ////////////////////////////////////////////////////////////
  // Results per layout
  ////////////////////////////////////////////////////////////

  // Basic mode looks at id bits 10..3 only
  assign match_basic  = hi0_pass;
  assign match_sf_std = hi0_pass & lo1_pass & d0_sf_pass & d1_sf_pass;
  // Either filter accepts
  assign match_df_std = (hi0_pass & lo1_pass & d0_df_pass) | (hi2_pass & lo3_pass);

endmodule

`default_nettype wire

// File: design/can_frame_pkg.sv
// Received frame types
`default_nettype none

`include "can_acf_consts.svh"

package can_frame_pkg;

  // Received identifier, standard frames use bits 10..0
  typedef logic [`ACF_EXT_ID_W-1:0] can_ext_id_t;

  // Identifier of a standard frame
  typedef logic [`ACF_STD_ID_W-1:0] can_std_id_t;

  // One data byte of the frame
  typedef logic [7:0] can_data_t;

  // Active filter layout
  typedef enum logic [1:0] {BASIC, SINGLE, DUAL} acf_mode_e;

endpackage

`default_nettype wire

// File: verif/can_acf_asserts.sv
// Acceptance filter protocol assertions
`timescale 1ns/1ps
`default_nettype none

module can_acf_asserts (
  input  logic clk,
  input  logic rst,
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_ack,
  input  logic go_rx_crc_lim,
  input  logic go_error_frame,
  input  logic id_ok
);

  // Failed assertions, summed into the closing verdict
  int fail_count = 0;

  // Classic ack lasts one cycle
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else
    begin
      fail_count++;
      $error("wb_ack stayed high for two cycles");
    end

  // Ack answers a request of the previous cycle
  ack_after_stb: assert property (@(posedge clk) disable iff (rst)
                                  wb_ack |-> $past(wb_cyc && wb_stb))
    else
    begin
      fail_count++;
      $error("wb_ack without a preceding request");
    end

  // Error frame clears the flag unless end of CRC wins
  error_clears: assert property (@(posedge clk) disable iff (rst)
                                 (go_error_frame && !go_rx_crc_lim) |=> !id_ok)
    else
    begin
      fail_count++;
      $error("id_ok not cleared after go_error_frame");
    end

endmodule

bind can_acf can_acf_asserts asserts_i (
  .clk            (clk),
  .rst            (rst),
  .wb_cyc         (wb_cyc),
  .wb_stb         (wb_stb),
  .wb_ack         (wb_ack),
  .go_rx_crc_lim  (go_rx_crc_lim),
  .go_error_frame (go_error_frame),
  .id_ok          (id_ok)
);

`default_nettype wire

// File: verif/can_acf_checker.sv
// Acceptance filter result checker
`timescale 1ns/1ps
`default_nettype none

module can_acf_checker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       extended_mode,
  input  logic                       acceptance_filter_mode,
  input  can_frame_pkg::can_ext_id_t id,
  input  logic                       go_rx_crc_lim,
  input  logic                       go_rx_inter,
  input  logic                       go_error_frame,
  input  logic                       id_ok,
  input  logic                       exp_id_ok,
  input  logic                       wb_ack,
  input  logic                       wb_we,
  input  logic [7:0]                 wb_dat_r,
  input  logic [7:0]                 exp_dat_r,
  output int                         check_count,
  output int                         mismatch_count
);

  import can_frame_pkg::*;

  // State of an event seen on the previous edge
  logic        pend;
  logic        pend_exp;
  acf_mode_e   pend_mode;
  can_ext_id_t pend_id;

  always @(posedge clk or posedge rst)
  begin : compare_proc
    int n_chk;
    int n_err;
    if (rst)
    begin
      pend           <= 1'b0;
      pend_exp       <= 1'b0;
      pend_mode      <= BASIC;
      pend_id        <= '0;
      check_count    <= 0;
      mismatch_count <= 0;
    end
    else
    begin
      n_chk = check_count;
      n_err = mismatch_count;
      // id_ok is visible one cycle after the event edge
      if (pend)
      begin
        n_chk++;
        if (id_ok !== pend_exp)
        begin
          n_err++;
          $display("[FAIL] id_ok: got 0x%0h, expected 0x%0h (mode %s, id 0x%08h)",
                   id_ok, pend_exp, pend_mode.name(), pend_id);
        end
      end
      // Read data is valid while ack is high
      if (wb_ack && !wb_we)
      begin
        n_chk++;
        if (wb_dat_r !== exp_dat_r)
        begin
          n_err++;
          $display("[FAIL] wb_dat_r: got 0x%02h, expected 0x%02h", wb_dat_r, exp_dat_r);
        end
      end
      // End of CRC takes the expected flag, a clear event expects 0
      pend      <= go_rx_crc_lim | go_rx_inter | go_error_frame;
      pend_exp  <= go_rx_crc_lim & exp_id_ok;
      pend_mode <= !extended_mode ? BASIC : (acceptance_filter_mode ? SINGLE : DUAL);
      pend_id   <= id;
      check_count    <= n_chk;
      mismatch_count <= n_err;
    end
  end

endmodule

`default_nettype wire

// File: verif/can_acf_stimulus.mem
// kind_flags_id_bits_d0_d1_exp, kind 1 write, 2 read, 3 frame, 4 clear, 0 end
// flags {ext, afm, ide, reset_mode}, bits {rtr1, rtr2, no_byte0, no_byte1} or {-, -, inter, error}
1_1_00000000_0_5a_00_0
2_1_00000000_0_5a_00_0
1_0_00000000_0_ff_00_0
2_0_00000000_0_5a_00_0
3_0_000002d5_0_00_00_1
3_0_000002f5_0_00_00_0
1_1_00000004_0_ff_00_0
3_0_00000123_0_00_00_1
1_1_00000004_0_00_00_0
1_1_00000001_0_a0_00_0
1_1_00000002_0_11_00_0
1_1_00000003_0_22_00_0
1_1_00000005_0_0f_00_0
2_1_00000005_0_0f_00_0
3_c_000002d5_0_11_22_1
3_c_000002d5_0_11_23_0
3_c_000002d5_1_11_23_1
3_c_000002d5_8_11_22_0
3_e_0b546224_0_00_00_1
3_e_0b546224_4_00_00_0
3_e_0b546225_0_00_00_0
3_8_000002d5_0_72_00_1
3_8_00000089_0_00_00_1
3_8_0000008b_0_00_00_0
3_a_02246000_0_00_00_0
3_a_02245fff_0_00_00_1
4_0_00000000_2_00_00_0
3_a_02245fff_0_00_00_1
4_0_00000000_1_00_00_0
0_0_00000000_0_00_00_0

// File: verif/tb_can_acf.sv
// CAN acceptance filter testbench
`timescale 1ns/1ps
`default_nettype none

module tb_can_acf;

  import can_acf_reg_pkg::*;
  import can_frame_pkg::*;

  localparam int STIM_DEPTH = 64;
  localparam int WAIT_LIMIT = 20;

  logic        clk;
  logic        rst;
  logic        reset_mode;
  logic        extended_mode;
  logic        acceptance_filter_mode;
  can_ext_id_t id;
  logic        rtr1;
  logic        rtr2;
  logic        ide;
  can_data_t   data0;
  can_data_t   data1;
  logic        no_byte0;
  logic        no_byte1;
  logic        go_rx_crc_lim;
  logic        go_rx_inter;
  logic        go_error_frame;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  acf_reg_e    wb_adr;
  acf_byte_t   wb_dat_w;
  logic        wb_ack;
  acf_byte_t   wb_dat_r;
  logic        id_ok;

  // Expected values handed to the checker
  logic        exp_id_ok;
  acf_byte_t   exp_dat_r;
  int          check_count;
  int          mismatch_count;
  int          timeout_count;
  int          issued;
  logic [63:0] stim_mem [0:STIM_DEPTH-1];

  can_acf can_acf_i (
    .clk                    (clk),
    .rst                    (rst),
    .reset_mode             (reset_mode),
    .extended_mode          (extended_mode),
    .acceptance_filter_mode (acceptance_filter_mode),
    .id                     (id),
    .rtr1                   (rtr1),
    .rtr2                   (rtr2),
    .ide                    (ide),
    .data0                  (data0),
    .data1                  (data1),
    .no_byte0               (no_byte0),
    .no_byte1               (no_byte1),
    .go_rx_crc_lim          (go_rx_crc_lim),
    .go_rx_inter            (go_rx_inter),
    .go_error_frame         (go_error_frame),
    .wb_cyc                 (wb_cyc),
    .wb_stb                 (wb_stb),
    .wb_we                  (wb_we),
    .wb_adr                 (wb_adr),
    .wb_dat_w               (wb_dat_w),
    .wb_ack                 (wb_ack),
    .wb_dat_r               (wb_dat_r),
    .id_ok                  (id_ok)
  );

  can_acf_checker checker_i (
    .clk                    (clk),
    .rst                    (rst),
    .extended_mode          (extended_mode),
    .acceptance_filter_mode (acceptance_filter_mode),
    .id                     (id),
    .go_rx_crc_lim          (go_rx_crc_lim),
    .go_rx_inter            (go_rx_inter),
    .go_error_frame         (go_error_frame),
    .id_ok                  (id_ok),
    .exp_id_ok              (exp_id_ok),
    .wb_ack                 (wb_ack),
    .wb_we                  (wb_we),
    .wb_dat_r               (wb_dat_r),
    .exp_dat_r              (exp_dat_r),
    .check_count            (check_count),
    .mismatch_count         (mismatch_count)
  );

  // 40 ns clock
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Bus and frame tasks, entered right after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic wait_ack();
    int n;
    n = 0;
    @(posedge clk);
    while (!wb_ack && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (!wb_ack)
    begin
      $display("Timeout: no Wishbone ack within %0d cycles", WAIT_LIMIT);
      timeout_count++;
    end
  endtask

  // Checker reports each issued check through its counter
  task automatic wait_checked();
    int n;
    n = 0;
    while (check_count < issued && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (check_count < issued)
    begin
      $display("Timeout: checker gave no result within %0d cycles", WAIT_LIMIT);
      timeout_count++;
      issued = check_count;
    end
  endtask

  task automatic run_record(input logic [63:0] rec);
    logic [3:0] kind;
    kind = rec[63:60];
    reset_mode <= rec[56];
    if (kind == 4'h1 || kind == 4'h2)
    begin
      // Register write or read, classic cycle held until ack
      wb_cyc    <= 1'b1;
      wb_stb    <= 1'b1;
      wb_we     <= (kind == 4'h1);
      wb_adr    <= acf_reg_e'(rec[26:24]);
      wb_dat_w  <= rec[19:12];
      exp_dat_r <= rec[19:12];
      if (kind == 4'h2)
        issued++;
      wait_ack();
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end
    else if (kind == 4'h3)
    begin
      // Frame fields stay until the next frame
      extended_mode          <= rec[59];
      acceptance_filter_mode <= rec[58];
      ide                    <= rec[57];
      id                     <= rec[52:24];
      rtr1                   <= rec[23];
      rtr2                   <= rec[22];
      no_byte0               <= rec[21];
      no_byte1               <= rec[20];
      data0                  <= rec[19:12];
      data1                  <= rec[11:4];
      exp_id_ok              <= rec[0];
      go_rx_crc_lim          <= 1'b1;
      issued++;
      @(posedge clk);
      go_rx_crc_lim <= 1'b0;
    end
    else
    begin
      // Clear event pulse
      go_rx_inter    <= rec[21];
      go_error_frame <= rec[20];
      issued++;
      @(posedge clk);
      go_rx_inter    <= 1'b0;
      go_error_frame <= 1'b0;
    end
    wait_checked();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int idx;
    int failures;
    rst = 1'b1;
    reset_mode = 1'b1;
    extended_mode = 1'b0;
    acceptance_filter_mode = 1'b0;
    id = '0;
    rtr1 = 1'b0;
    rtr2 = 1'b0;
    ide = 1'b0;
    data0 = '0;
    data1 = '0;
    no_byte0 = 1'b0;
    no_byte1 = 1'b0;
    go_rx_crc_lim = 1'b0;
    go_rx_inter = 1'b0;
    go_error_frame = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = CODE0;
    wb_dat_w = '0;
    exp_id_ok = 1'b0;
    exp_dat_r = '0;
    timeout_count = 0;
    issued = 0;
    $readmemh("verif/can_acf_stimulus.mem", stim_mem);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // Kinds 1 to 4 are records, anything else ends the list
    idx = 0;
    while (idx < STIM_DEPTH && stim_mem[idx][63:60] >= 4'h1 && stim_mem[idx][63:60] <= 4'h4)
    begin
      @(posedge clk);
      run_record(stim_mem[idx]);
      idx++;
    end
    @(posedge clk);
    failures = mismatch_count + timeout_count + can_acf_i.asserts_i.fail_count;
    if (idx == 0)
    begin
      $display("No records were read from the stimulus file");
      failures++;
    end
    $display("Records: %0d, checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             idx, check_count, mismatch_count, timeout_count,
             can_acf_i.asserts_i.fail_count);
    if (failures == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
